/* hw/lsab_pkg.sv */
package lsab_pkg;

  // ************************************************************************
  // sizes

  localparam int LANES        = 4;
  localparam int WORD_W       = 32;
  localparam int LANE_DEPTH   = 16;
  localparam int LANE_PTR_W   = $clog2(LANE_DEPTH);
  localparam int STORE_ADDR_W = 9;
  localparam int STORE_WORDS  = 1 << STORE_ADDR_W;
  localparam int COUNT_W      = 6;

  typedef logic [$clog2(LANES)-1:0] lane_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [STORE_ADDR_W-1:0]  store_addr_t;  // addresses wrap modulo the store size.
  typedef logic [COUNT_W-1:0]       count_t;
  typedef logic [LANE_PTR_W-1:0]    lane_ptr_t;
  typedef logic [LANE_PTR_W:0]      lane_used_t;   // one extra bit so a full lane is visible.
  typedef word_t [LANES-1:0]        lane_words_t;

  // ************************************************************************
  // commands, mover states and status

  typedef enum logic {OP_FILL, OP_EMPTY} cmd_op_e;

  typedef struct packed {
    cmd_op_e     op;
    lane_t       lane;
    store_addr_t start;
    count_t      count;
  } block_cmd_t;

  typedef enum logic [1:0] {IDLE, MOVE, FINISH} mover_state_e;

  typedef struct packed {
    logic   busy;
    logic   done;
    logic   abrupt;
    count_t sent;
  } xfer_status_t;

endpackage

/* hw/lsab_in_buffer.sv */
`timescale 1ns/10ps

module lsab_in_buffer (
  input  logic                            CLK_n,
  input  logic                            RST_MASTER,
  input  logic [lsab_pkg::LANES-1:0]      i_wr_strobe,
  input  lsab_pkg::lane_words_t           i_wr_data,
  input  lsab_pkg::lane_t                 i_rd_lane,
  input  logic                            i_rd_strobe,
  output lsab_pkg::word_t                 o_rd_word,
  output logic                            o_rd_empty
);
  import lsab_pkg::*;

  lane_words_t      heads;
  logic [LANES-1:0] lane_empty;

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    word_t      mem [LANE_DEPTH];
    lane_ptr_t  wr_ptr;
    lane_ptr_t  rd_ptr;
    lane_used_t used;
    logic       push;
    logic       pop;

    assign push = i_wr_strobe[g] && (used != lane_used_t'(LANE_DEPTH)); // a full lane drops the word.
    assign pop  = i_rd_strobe && (i_rd_lane == lane_t'(g)) && (used != '0);

    always_ff @(posedge CLK_n)
    begin
      if (push)
      begin
        mem[wr_ptr] <= i_wr_data[g];
      end
    end

    always_ff @(posedge CLK_n)
    begin
      if (RST_MASTER)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        used   <= '0;
      end
      else
      begin
        if (push)
        begin
          wr_ptr <= wr_ptr + lane_ptr_t'(1);
        end
        if (pop)
        begin
          rd_ptr <= rd_ptr + lane_ptr_t'(1);
        end
        used <= used + lane_used_t'(push) - lane_used_t'(pop);
      end
    end

    assign heads[g]      = mem[rd_ptr];  // the head falls through without a read cycle.
    assign lane_empty[g] = (used == '0);
  end

  assign o_rd_word  = heads[i_rd_lane];
  assign o_rd_empty = lane_empty[i_rd_lane];

endmodule

/* hw/lsab_out_buffer.sv */
`timescale 1ns/10ps

module lsab_out_buffer (
  input  logic                            CLK_n,
  input  logic                            RST_MASTER,
  input  lsab_pkg::lane_t                 i_wr_lane,
  input  logic                            i_wr_strobe,
  input  lsab_pkg::word_t                 i_wr_word,
  input  logic [lsab_pkg::LANES-1:0]      i_rd_strobe,
  output logic                            o_room,
  output lsab_pkg::lane_words_t           o_rd_data,
  output logic [lsab_pkg::LANES-1:0]      o_empty
);
  import lsab_pkg::*;

  logic [LANES-1:0] room;

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    word_t      mem [LANE_DEPTH];
    lane_ptr_t  wr_ptr;
    lane_ptr_t  rd_ptr;
    lane_used_t used;
    logic       push;
    logic       pop;

    assign push = i_wr_strobe && (i_wr_lane == lane_t'(g)) && (used != lane_used_t'(LANE_DEPTH));
    assign pop  = i_rd_strobe[g] && (used != '0); // a host read of an empty lane is ignored.

    always_ff @(posedge CLK_n)
    begin
      if (push)
      begin
        mem[wr_ptr] <= i_wr_word;
      end
    end

    always_ff @(posedge CLK_n)
    begin
      if (RST_MASTER)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        used   <= '0;
      end
      else
      begin
        if (push)
        begin
          wr_ptr <= wr_ptr + lane_ptr_t'(1);
        end
        if (pop)
        begin
          rd_ptr <= rd_ptr + lane_ptr_t'(1);
        end
        used <= used + lane_used_t'(push) - lane_used_t'(pop);
      end
    end

    assign o_rd_data[g] = mem[rd_ptr];
    assign o_empty[g]   = (used == '0);
    assign room[g]      = (used <= lane_used_t'(LANE_DEPTH - 2)); // two slots cover a word in flight.
  end

  assign o_room = room[i_wr_lane];

endmodule

/* hw/block_store.sv */
`timescale 1ns/10ps

module block_store (
  input  logic                  CLK_n,
  input  logic                  i_wr_en,
  input  lsab_pkg::store_addr_t i_wr_addr,
  input  lsab_pkg::word_t       i_wr_word,
  input  lsab_pkg::store_addr_t i_rd_addr,
  output lsab_pkg::word_t       o_rd_word
);
  import lsab_pkg::*;

  word_t mem [STORE_WORDS];

  always_ff @(posedge CLK_n)
  begin
    if (i_wr_en)
    begin
      mem[i_wr_addr] <= i_wr_word;
    end
  end

  // reads every cycle and the empty mover decides which data counts.
  always_ff @(posedge CLK_n)
  begin
    o_rd_word <= mem[i_rd_addr];
  end

endmodule

/* hw/block_fill_mover.sv */
`timescale 1ns/10ps

module block_fill_mover (
  input  logic                  CLK_n,
  input  logic                  RST_MASTER,
  input  logic                  i_start,
  input  lsab_pkg::block_cmd_t  i_cmd,
  input  lsab_pkg::word_t       i_lane_word,
  input  logic                  i_lane_empty,
  output logic                  o_lane_rd,
  output logic                  o_store_wr,
  output lsab_pkg::store_addr_t o_store_addr,
  output lsab_pkg::word_t       o_store_word,
  output logic                  o_finish,
  output logic                  o_abrupt,
  output lsab_pkg::count_t      o_sent
);
  import lsab_pkg::*;

  mover_state_e state;
  store_addr_t  addr;
  count_t       remain;
  count_t       sent;
  logic         abrupt;
  logic         take;

  assign take = (state == MOVE) && (remain != '0) && !i_lane_empty; // one word per cycle.

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      state  <= IDLE;
      addr   <= '0;
      remain <= '0;
      sent   <= '0;
      abrupt <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (i_start)
          begin
            addr   <= i_cmd.start;
            remain <= i_cmd.count;
            sent   <= '0;
            abrupt <= 1'b0;
            state  <= MOVE;
          end
        end
        MOVE:
        begin
          if (take)
          begin
            addr   <= addr + store_addr_t'(1);
            remain <= remain - count_t'(1);
            sent   <= sent + count_t'(1);
          end
          else
          begin
            abrupt <= (remain != '0);  // the lane ran dry with words still owed.
            state  <= FINISH;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign o_lane_rd    = take;
  assign o_store_wr   = take;
  assign o_store_addr = addr;
  assign o_store_word = i_lane_word;
  assign o_finish     = (state == FINISH);
  assign o_abrupt     = abrupt;
  assign o_sent       = sent;

endmodule

/* hw/block_empty_mover.sv */
`timescale 1ns/10ps

module block_empty_mover (
  input  logic                  CLK_n,
  input  logic                  RST_MASTER,
  input  logic                  i_start,
  input  lsab_pkg::block_cmd_t  i_cmd,
  input  lsab_pkg::word_t       i_store_word,
  input  logic                  i_room,
  output lsab_pkg::store_addr_t o_store_addr,
  output logic                  o_lane_wr,
  output lsab_pkg::word_t       o_lane_word,
  output logic                  o_finish,
  output lsab_pkg::count_t      o_sent
);
  import lsab_pkg::*;

  mover_state_e state;
  store_addr_t  addr;
  count_t       remain;
  count_t       sent;
  logic         issue;
  logic         rd_valid;

  // ************************************************************************
  // stage 0 issues the address, stage 1 writes the returning word.

  assign issue = (state == MOVE) && (remain != '0) && i_room;  // stalls while the lane is tight.

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      state    <= IDLE;
      addr     <= '0;
      remain   <= '0;
      sent     <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= issue;
      case (state)
        IDLE:
        begin
          if (i_start)
          begin
            addr   <= i_cmd.start;
            remain <= i_cmd.count;
            sent   <= '0;
            state  <= MOVE;
          end
        end
        MOVE:
        begin
          if (issue)
          begin
            addr   <= addr + store_addr_t'(1);
            remain <= remain - count_t'(1);
          end
          if (rd_valid)
          begin
            sent <= sent + count_t'(1);
          end
          if ((remain == '0) && !rd_valid)
          begin
            state <= FINISH;  // nothing left to issue and nothing in flight.
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign o_store_addr = addr;
  assign o_lane_wr    = rd_valid;
  assign o_lane_word  = i_store_word;
  assign o_finish     = (state == FINISH);
  assign o_sent       = sent;

endmodule

/* hw/transfer_ctrl.sv */
`timescale 1ns/10ps

module transfer_ctrl (
  input  logic                    CLK_n,
  input  logic                    RST_MASTER,
  input  logic                    i_cmd_strobe,
  input  lsab_pkg::block_cmd_t    i_cmd,
  input  logic                    i_fill_finish,
  input  logic                    i_fill_abrupt,
  input  lsab_pkg::count_t        i_fill_sent,
  input  logic                    i_empty_finish,
  input  lsab_pkg::count_t        i_empty_sent,
  output logic                    o_fill_start,
  output logic                    o_empty_start,
  output lsab_pkg::block_cmd_t    o_cmd,
  output lsab_pkg::xfer_status_t  o_status
);
  import lsab_pkg::*;

  block_cmd_t cmd_q;
  logic       busy;
  logic       done;
  logic       abrupt;
  count_t     sent;
  logic       accept;
  logic       finish;

  assign accept = i_cmd_strobe && !busy;  // a strobe during a transfer is dropped.
  assign finish = i_fill_finish || i_empty_finish;

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      cmd_q         <= '0;
      busy          <= 1'b0;
      done          <= 1'b0;
      abrupt        <= 1'b0;
      sent          <= '0;
      o_fill_start  <= 1'b0;
      o_empty_start <= 1'b0;
    end
    else
    begin
      o_fill_start  <= 1'b0;
      o_empty_start <= 1'b0;
      done          <= finish;
      abrupt        <= i_fill_finish && i_fill_abrupt;
      if (accept)
      begin
        cmd_q <= i_cmd;
        busy  <= 1'b1;
        case (i_cmd.op)
          OP_FILL:  o_fill_start  <= 1'b1;
          OP_EMPTY: o_empty_start <= 1'b1;
          default:  o_fill_start  <= 1'b0;
        endcase
      end
      if (finish)
      begin
        busy <= 1'b0;  // falls on the same edge as done.
        sent <= i_fill_finish ? i_fill_sent : i_empty_sent;
      end
    end
  end

  assign o_cmd           = cmd_q;
  assign o_status.busy   = busy;
  assign o_status.done   = done;
  assign o_status.abrupt = abrupt;
  assign o_status.sent   = sent;

endmodule

/* hw/lsab_core.sv */
`timescale 1ns/10ps

module lsab_core (
  input  logic                            CLK_n,
  input  logic                            RST_MASTER,
  input  logic [lsab_pkg::LANES-1:0]      i_wr_strobe,
  input  lsab_pkg::lane_words_t           i_wr_data,
  input  logic                            i_cmd_strobe,
  input  lsab_pkg::block_cmd_t            i_cmd,
  input  logic [lsab_pkg::LANES-1:0]      i_rd_strobe,
  output lsab_pkg::lane_words_t           o_rd_data,
  output logic [lsab_pkg::LANES-1:0]      o_out_empty,
  output lsab_pkg::xfer_status_t          o_status
);
  import lsab_pkg::*;

  block_cmd_t  cmd;
  logic        fill_start, empty_start;
  word_t       in_word, fill_word, store_word, out_word;
  logic        in_empty, fill_rd, fill_wr, out_wr, out_room;
  store_addr_t fill_addr, empty_addr;
  logic        fill_finish, fill_abrupt, empty_finish;
  count_t      fill_sent, empty_sent;

  transfer_ctrl ctrl (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .i_cmd_strobe(i_cmd_strobe),
    .i_cmd(i_cmd), .i_fill_finish(fill_finish), .i_fill_abrupt(fill_abrupt),
    .i_fill_sent(fill_sent), .i_empty_finish(empty_finish), .i_empty_sent(empty_sent),
    .o_fill_start(fill_start), .o_empty_start(empty_start), .o_cmd(cmd), .o_status(o_status));

  lsab_in_buffer lane_in (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .i_wr_strobe(i_wr_strobe),
    .i_wr_data(i_wr_data), .i_rd_lane(cmd.lane), .i_rd_strobe(fill_rd), .o_rd_word(in_word),
    .o_rd_empty(in_empty));

  block_fill_mover fill (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .i_start(fill_start),
    .i_cmd(cmd), .i_lane_word(in_word), .i_lane_empty(in_empty), .o_lane_rd(fill_rd),
    .o_store_wr(fill_wr), .o_store_addr(fill_addr), .o_store_word(fill_word),
    .o_finish(fill_finish), .o_abrupt(fill_abrupt), .o_sent(fill_sent));

  block_store store (.CLK_n(CLK_n), .i_wr_en(fill_wr), .i_wr_addr(fill_addr),
    .i_wr_word(fill_word), .i_rd_addr(empty_addr), .o_rd_word(store_word));

  block_empty_mover empty (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .i_start(empty_start),
    .i_cmd(cmd), .i_store_word(store_word), .i_room(out_room), .o_store_addr(empty_addr),
    .o_lane_wr(out_wr), .o_lane_word(out_word), .o_finish(empty_finish), .o_sent(empty_sent));

  lsab_out_buffer lane_out (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .i_wr_lane(cmd.lane),
    .i_wr_strobe(out_wr), .i_wr_word(out_word), .i_rd_strobe(i_rd_strobe), .o_room(out_room),
    .o_rd_data(o_rd_data), .o_empty(o_out_empty));

endmodule

/* verification/lsab_core_chk.sv */
`timescale 1ns/10ps

module lsab_core_chk (
  input logic                   CLK_n,
  input logic                   RST_MASTER,
  input lsab_pkg::xfer_status_t i_status,
  input lsab_pkg::block_cmd_t   i_cmd,
  input logic                   i_fill_start,
  input logic                   i_empty_start
);
  import lsab_pkg::*;

  // **************************************************************************
  // status and start rules

  // an abrupt stop closes a fill that moved fewer words than its count.
  abrupt_with_done: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    i_status.abrupt |-> i_status.done && (i_cmd.op == OP_FILL)
                        && (i_status.sent != i_cmd.count))
    else $error("abrupt pulse without done at the end of a short fill");

  single_done: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    i_status.done |=> !i_status.done)
    else $error("done high in two cycles in a row");

  start_needs_busy: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    !i_status.busy |-> !(i_fill_start || i_empty_start))
    else $error("mover start while busy is low");

endmodule

bind lsab_core lsab_core_chk i_chk (
  .CLK_n         (CLK_n),
  .RST_MASTER    (RST_MASTER),
  .i_status      (o_status),
  .i_cmd         (cmd),
  .i_fill_start  (fill_start),
  .i_empty_start (empty_start)
);

/* verification/lsab_core_tb.sv */
`timescale 1ns/10ps

module lsab_core_tb;
  import lsab_pkg::*;

  logic             CLK_n;
  logic             RST_MASTER;
  logic [LANES-1:0] i_wr_strobe;
  lane_words_t      i_wr_data;
  logic             i_cmd_strobe;
  block_cmd_t       i_cmd;
  logic [LANES-1:0] i_rd_strobe;
  lane_words_t      o_rd_data;
  logic [LANES-1:0] o_out_empty;
  xfer_status_t     o_status;

  string      lines[$];
  int         errors;
  int         checks;
  int         done_pulses;
  int         cmds_run;
  int         watchdog_cycles;
  logic       stim_ready = 1'b0;
  logic       drain_on;     // the next command runs while the host drains drain_lane.
  lane_t      drain_lane;
  word_t      drain_word;
  int         drain_left;
  logic       ignored_on;   // ignored_cmd is strobed while the next command is busy.
  block_cmd_t ignored_cmd;

  lsab_core i_lsab_core (
    .CLK_n        (CLK_n),
    .RST_MASTER   (RST_MASTER),
    .i_wr_strobe  (i_wr_strobe),
    .i_wr_data    (i_wr_data),
    .i_cmd_strobe (i_cmd_strobe),
    .i_cmd        (i_cmd),
    .i_rd_strobe  (i_rd_strobe),
    .o_rd_data    (o_rd_data),
    .o_out_empty  (o_out_empty),
    .o_status     (o_status)
  );

  initial
  begin
    CLK_n = 1'b0;
    forever
    begin
      #20 CLK_n = ~CLK_n;
    end
  end

  always @(negedge CLK_n)
  begin
    if (!RST_MASTER && o_status.done)
    begin
      done_pulses++;
    end
  end

  initial
  begin
    wait (stim_ready);
    repeat (watchdog_cycles) @(posedge CLK_n);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

  // **************************************************************************
  // host side tasks, all entered and left 2 ns after a rising edge

  task automatic step();
    @(posedge CLK_n);
    #2;
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic write_lane(input lane_t lane, input word_t first, input int count);
    for (int i = 0; i < count; i++)
    begin
      i_wr_strobe[lane] = 1'b1;
      i_wr_data[lane]   = first + 32'(i);
      step();
    end
    i_wr_strobe = '0;
  endtask

  task automatic read_lane(input lane_t lane, input word_t first, input int count);
    for (int i = 0; i < count; i++)
    begin
      check_value($sformatf("o_out_empty[%0d]", lane), 32'd0, 32'(o_out_empty[lane]));
      check_value($sformatf("o_rd_data[%0d]", lane), first + 32'(i), o_rd_data[lane]);
      i_rd_strobe[lane] = 1'b1;
      step();
      i_rd_strobe = '0;
    end
  endtask

  task automatic run_command(input block_cmd_t cmd, input word_t exp_sent, input word_t exp_abrupt);
    int   cycles;
    logic done_seen;
    cycles       = 0;
    done_seen    = 1'b0;
    i_cmd        = cmd;
    i_cmd_strobe = 1'b1;
    step();
    cmds_run++;
    check_value("o_status.busy", 32'd1, 32'(o_status.busy));
    i_cmd        = ignored_cmd;
    i_cmd_strobe = ignored_on;  // a second strobe lands while busy is high.
    step();
    i_cmd_strobe = 1'b0;
    ignored_on   = 1'b0;
    while ((!done_seen || (drain_on && drain_left > 0)) && cycles < 300)
    begin
      if (o_status.done && !done_seen)
      begin
        done_seen = 1'b1;
        check_value("o_status.sent", exp_sent, 32'(o_status.sent));
        check_value("o_status.abrupt", exp_abrupt, 32'(o_status.abrupt));
        check_value("o_status.busy", 32'd0, 32'(o_status.busy));
      end
      i_rd_strobe = '0;
      if (drain_on && cycles[0] && drain_left > 0 && !o_out_empty[drain_lane])
      begin
        check_value($sformatf("o_rd_data[%0d]", drain_lane), drain_word, o_rd_data[drain_lane]);
        i_rd_strobe[drain_lane] = 1'b1;  // every second cycle, so the lane fills up.
        drain_word++;
        drain_left--;
      end
      step();
      cycles++;
    end
    i_rd_strobe = '0;
    if (!done_seen || (drain_on && drain_left > 0))
    begin
      errors++;
      $display("command on lane %0d did not finish within 300 cycles (done %0b, %0d undrained)",
               cmd.lane, done_seen, drain_left);
    end
    drain_on   = 1'b0;
    drain_left = 0;
  endtask

  // **************************************************************************
  // main sequence

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [31:0] f [6];
    errors       = 0;
    checks       = 0;
    done_pulses  = 0;
    cmds_run     = 0;
    drain_on     = 1'b0;
    drain_lane   = '0;
    drain_word   = '0;
    drain_left   = 0;
    ignored_on   = 1'b0;
    ignored_cmd  = '0;
    RST_MASTER   = 1'b1;
    i_wr_strobe  = '0;
    i_wr_data    = '0;
    i_cmd_strobe = 1'b0;
    i_cmd        = '0;
    i_rd_strobe  = '0;
    fd = $fopen("verification/lsab_stimulus.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open verification/lsab_stimulus.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#")
        begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    watchdog_cycles = 100 * lines.size() + 200;
    stim_ready      = 1'b1;

    repeat (5) @(posedge CLK_n);
    #2;
    RST_MASTER = 1'b0;
    step();
    check_value("o_status.busy", 32'd0, 32'(o_status.busy));
    check_value("o_status.done", 32'd0, 32'(o_status.done));
    check_value("o_status.abrupt", 32'd0, 32'(o_status.abrupt));
    check_value("o_status.sent", 32'd0, 32'(o_status.sent));
    check_value("o_out_empty", 32'hf, 32'(o_out_empty));

    foreach (lines[i])
    begin
      line = lines[i];
      kind = line.getc(0);
      n    = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5]);
      case (kind)
        "W": write_lane(f[0][1:0], f[1], int'(f[2]));
        "R": read_lane(f[0][1:0], f[1], int'(f[2]));
        "C": run_command({f[0][0], f[1][1:0], f[2][8:0], f[3][5:0]}, f[4], f[5]);
        "E": check_value($sformatf("o_out_empty[%0d]", f[0][1:0]), 32'd1,
                         32'(o_out_empty[f[0][1:0]]));
        "D":
        begin
          drain_on   = 1'b1;
          drain_lane = f[0][1:0];
          drain_word = f[1];
          drain_left = int'(f[2]);
        end
        "I":
        begin
          ignored_on  = 1'b1;
          ignored_cmd = {f[0][0], f[1][1:0], f[2][8:0], f[3][5:0]};
        end
        default:
        begin
          errors++;
          $display("unknown stimulus line: %s", line);
        end
      endcase
    end

    repeat (20) step();
    check_value("done pulse count", 32'(cmds_run), 32'(done_pulses));  // one per command.
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verification/lsab_stimulus.txt */
# all fields hex. W lane word n: n writes to an input lane, the word counting up from word.
# C op lane start count sent abrupt: op 0 fill, 1 empty, then wait for done and check status.
# R lane word n: check and pop n output words. D lane word n: drain during the next command.
# I op lane start count: strobed while the next command is busy. E lane: output lane is empty.
W 1 11110000 5
C 0 1 1fe 5 5 0
C 1 3 1fe 5 5 0
R 3 11110000 5
W 2 22220000 3
C 0 2 064 a 3 1
C 1 0 064 3 3 0
R 0 22220000 3
W 0 44440000 11
C 0 0 0c8 14 10 1
W 3 44440010 10
C 0 3 0d8 10 10 0
W 1 44440020 8
C 0 1 0e8 8 8 0
D 2 44440000 28
C 1 2 0c8 28 28 0
C 0 0 000 0 0 0
W 2 77770000 4
I 1 1 0c8 4
C 0 2 12c 4 4 0
E 1
C 1 0 12c 4 4 0
R 0 77770000 4
E 0

/* project.f */
hw/lsab_pkg.sv
hw/lsab_in_buffer.sv
hw/lsab_out_buffer.sv
hw/block_store.sv
hw/block_fill_mover.sv
hw/block_empty_mover.sv
hw/transfer_ctrl.sv
hw/lsab_core.sv
verification/lsab_core_chk.sv
verification/lsab_core_tb.sv

/* Makefile */
TOP := lsab_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
